// ==== rtl/dispatch_config.svh ====
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// rename group size, lane 0 is the oldest
`define RENAME_WIDTH 2

// entries the integer queue offers to issue per cycle
`define INTDQ_DISP_WID 2

// integer dispatch queue depth, power of two
`define INTDQ_DEPTH 8

// immediate buffer
`define IMMBUF_SIZE 8
`define IMMBUF_READPORT_NUM 2
`define IMMBUF_CLEARPORT_NUM 2

// rob entries, sets the rob index width
`define ROB_SIZE 32

// physical integer registers
`define PREG_NUM 64

`endif

// ==== rtl/dispatch_pkg.sv ====
`default_nettype none

`include "dispatch_config.svh"

package dispatch_pkg;

    // rob entry index
    typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

    // slot in the immediate buffer
    typedef logic [$clog2(`IMMBUF_SIZE)-1:0] irob_idx_t;

    // physical register number
    typedef logic [$clog2(`PREG_NUM)-1:0] preg_idx_t;

    // raw immediate as produced by decode
    typedef logic [19:0] imm_t;

    // micro-op code for the issue side
    typedef logic [6:0] micop_t;

    // exception cause from frontend or decode
    typedef logic [3:0] except_t;

    // which execution block an instruction belongs to
    typedef enum logic {
        DISP_INT = 1'b0,
        DISP_MEM = 1'b1
    } disp_target_t;

endpackage

`default_nettype wire

// ==== rtl/int_disp_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_config.svh"

module int_disp_queue #(
    parameter int DEPTH   = `INTDQ_DEPTH,
    parameter int IN_NUM  = `RENAME_WIDTH,
    parameter int OUT_NUM = `INTDQ_DISP_WID
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_flush,

    output logic                        o_can_enq,
    input  wire                         i_enq_vld,
    input  wire  [IN_NUM-1:0]           i_enq_req,
    input  dispatch_pkg::rob_idx_t      i_enq_rob_idx [IN_NUM],
    input  dispatch_pkg::irob_idx_t     i_enq_irob_idx [IN_NUM],
    input  wire  [IN_NUM-1:0]           i_enq_use_imm,
    input  dispatch_pkg::preg_idx_t     i_enq_iprd [IN_NUM],
    input  dispatch_pkg::preg_idx_t     i_enq_iprs1 [IN_NUM],
    input  dispatch_pkg::preg_idx_t     i_enq_iprs2 [IN_NUM],
    input  dispatch_pkg::micop_t        i_enq_micop [IN_NUM],

    output logic [OUT_NUM-1:0]          o_deq_vld,
    input  wire  [OUT_NUM-1:0]          i_deq_req,
    output dispatch_pkg::rob_idx_t      o_deq_rob_idx [OUT_NUM],
    output dispatch_pkg::irob_idx_t     o_deq_irob_idx [OUT_NUM],
    output logic [OUT_NUM-1:0]          o_deq_use_imm,
    output dispatch_pkg::preg_idx_t     o_deq_iprd [OUT_NUM],
    output dispatch_pkg::preg_idx_t     o_deq_iprs1 [OUT_NUM],
    output dispatch_pkg::preg_idx_t     o_deq_iprs2 [OUT_NUM],
    output dispatch_pkg::micop_t        o_deq_micop [OUT_NUM]
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage, one array per field
    dispatch_pkg::rob_idx_t  rob_idx_mem [DEPTH];
    dispatch_pkg::irob_idx_t irob_idx_mem [DEPTH];
    logic [DEPTH-1:0]        use_imm_mem;
    dispatch_pkg::preg_idx_t iprd_mem [DEPTH];
    dispatch_pkg::preg_idx_t iprs1_mem [DEPTH];
    dispatch_pkg::preg_idx_t iprs2_mem [DEPTH];
    dispatch_pkg::micop_t    micop_mem [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0] wr_ptr [IN_NUM];
    logic [CNT_W-1:0] enq_num;
    logic [CNT_W-1:0] deq_num;

    // room for a whole rename group
    assign o_can_enq = (CNT_W'(DEPTH) - count) >= CNT_W'(IN_NUM);

    // compact requested lanes onto consecutive slots from tail
    always_comb begin
        logic [PTR_W-1:0] slot;
        slot = tail;
        enq_num = '0;
        for (int i = 0; i < IN_NUM; i++) begin
            wr_ptr[i] = slot;
            if (i_enq_req[i]) begin
                slot = slot + PTR_W'(1);
                if (i_enq_vld) begin
                    enq_num = enq_num + CNT_W'(1);
                end
            end
        end
    end

    // deq request is a prefix of o_deq_vld
    always_comb begin
        deq_num = '0;
        for (int k = 0; k < OUT_NUM; k++) begin
            if (i_deq_req[k] && o_deq_vld[k]) begin
                deq_num = deq_num + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(deq_num);
            tail  <= tail + PTR_W'(enq_num);
            count <= count + enq_num - deq_num;
        end
    end

    always_ff @(posedge clk) begin
        if (i_enq_vld && !i_flush) begin
            for (int i = 0; i < IN_NUM; i++) begin
                if (i_enq_req[i]) begin
                    rob_idx_mem[wr_ptr[i]]  <= i_enq_rob_idx[i];
                    irob_idx_mem[wr_ptr[i]] <= i_enq_irob_idx[i];
                    use_imm_mem[wr_ptr[i]]  <= i_enq_use_imm[i];
                    iprd_mem[wr_ptr[i]]     <= i_enq_iprd[i];
                    iprs1_mem[wr_ptr[i]]    <= i_enq_iprs1[i];
                    iprs2_mem[wr_ptr[i]]    <= i_enq_iprs2[i];
                    micop_mem[wr_ptr[i]]    <= i_enq_micop[i];
                end
            end
        end
    end

    // oldest entries first on the output ports
    genvar k;
    generate
        for (k = 0; k < OUT_NUM; k++) begin : g_deq
            logic [PTR_W-1:0] rd_ptr;
            assign rd_ptr            = head + PTR_W'(k);
            assign o_deq_vld[k]      = count > CNT_W'(k);
            assign o_deq_rob_idx[k]  = rob_idx_mem[rd_ptr];
            assign o_deq_irob_idx[k] = irob_idx_mem[rd_ptr];
            assign o_deq_use_imm[k]  = use_imm_mem[rd_ptr];
            assign o_deq_iprd[k]     = iprd_mem[rd_ptr];
            assign o_deq_iprs1[k]    = iprs1_mem[rd_ptr];
            assign o_deq_iprs2[k]    = iprs2_mem[rd_ptr];
            assign o_deq_micop[k]    = micop_mem[rd_ptr];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== rtl/imm_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_config.svh"

module imm_buffer #(
    parameter int SIZE      = `IMMBUF_SIZE,
    parameter int IN_NUM    = `RENAME_WIDTH,
    parameter int READ_NUM  = `IMMBUF_READPORT_NUM,
    parameter int CLEAR_NUM = `IMMBUF_CLEARPORT_NUM
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_flush,

    output logic                        o_can_enq,
    input  wire                         i_enq_vld,
    input  wire  [IN_NUM-1:0]           i_enq_req,
    input  dispatch_pkg::imm_t          i_enq_imm [IN_NUM],
    output dispatch_pkg::irob_idx_t     o_alloc_idx [IN_NUM],

    input  dispatch_pkg::irob_idx_t     i_read_idx [READ_NUM],
    output dispatch_pkg::imm_t          o_read_data [READ_NUM],

    input  wire  [CLEAR_NUM-1:0]        i_clear_vld,
    input  dispatch_pkg::irob_idx_t     i_clear_idx [CLEAR_NUM]
);

    localparam int CNT_W = $clog2(SIZE + 1);

    dispatch_pkg::imm_t imm_mem [SIZE];

    // one bit per slot, set while an instruction holds it
    logic [SIZE-1:0]  busy;
    logic [SIZE-1:0]  alloc_mask;
    logic [SIZE-1:0]  clear_mask;
    logic [CNT_W-1:0] free_cnt;

    always_comb begin
        free_cnt = '0;
        for (int s = 0; s < SIZE; s++) begin
            if (!busy[s]) begin
                free_cnt = free_cnt + CNT_W'(1);
            end
        end
    end

    assign o_can_enq = free_cnt >= CNT_W'(IN_NUM);

    // lowest free slot per lane, earlier lanes take theirs first
    always_comb begin
        logic [SIZE-1:0] avail;
        logic            found;
        avail = ~busy;
        alloc_mask = '0;
        for (int i = 0; i < IN_NUM; i++) begin
            found = 1'b0;
            o_alloc_idx[i] = '0;
            for (int s = 0; s < SIZE; s++) begin
                if (!found && avail[s]) begin
                    o_alloc_idx[i] = dispatch_pkg::irob_idx_t'(s);
                    found = 1'b1;
                end
            end
            if (i_enq_req[i] && found) begin
                avail[o_alloc_idx[i]] = 1'b0;
                alloc_mask[o_alloc_idx[i]] = 1'b1;
            end
        end
    end

    // writeback frees slots
    always_comb begin
        clear_mask = '0;
        for (int c = 0; c < CLEAR_NUM; c++) begin
            if (i_clear_vld[c]) begin
                clear_mask[i_clear_idx[c]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            busy <= '0;
        end else if (i_enq_vld) begin
            busy <= (busy & ~clear_mask) | alloc_mask;
        end else begin
            busy <= busy & ~clear_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (i_enq_vld && !i_flush) begin
            for (int i = 0; i < IN_NUM; i++) begin
                if (i_enq_req[i]) begin
                    imm_mem[o_alloc_idx[i]] <= i_enq_imm[i];
                end
            end
        end
    end

    genvar r;
    generate
        for (r = 0; r < READ_NUM; r++) begin : g_read
            assign o_read_data[r] = imm_mem[i_read_idx[r]];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== rtl/dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_config.svh"

module dispatch (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_squash,

    // rename group
    output logic                         o_stall,
    input  wire  [`RENAME_WIDTH-1:0]     i_enq_vld,
    input  dispatch_pkg::disp_target_t   i_enq_target [`RENAME_WIDTH],
    input  wire  [`RENAME_WIDTH-1:0]     i_enq_is_mv,
    input  wire  [`RENAME_WIDTH-1:0]     i_enq_use_imm,
    input  dispatch_pkg::imm_t           i_enq_imm [`RENAME_WIDTH],
    input  wire  [`RENAME_WIDTH-1:0]     i_enq_rd_wen,
    input  dispatch_pkg::preg_idx_t      i_enq_iprd [`RENAME_WIDTH],
    input  dispatch_pkg::preg_idx_t      i_enq_iprs1 [`RENAME_WIDTH],
    input  dispatch_pkg::preg_idx_t      i_enq_iprs2 [`RENAME_WIDTH],
    input  dispatch_pkg::micop_t         i_enq_micop [`RENAME_WIDTH],
    input  wire  [`RENAME_WIDTH-1:0]     i_enq_has_except,
    input  dispatch_pkg::except_t        i_enq_except [`RENAME_WIDTH],

    // rob
    input  wire                          i_can_insert_rob,
    input  dispatch_pkg::rob_idx_t       i_alloc_rob_idx [`RENAME_WIDTH],
    output logic                         o_insert_rob_vld,
    output logic [`RENAME_WIDTH-1:0]     o_insert_rob_req,
    output logic [`RENAME_WIDTH-1:0]     o_insert_rob_ismv,
    output logic [`RENAME_WIDTH-1:0]     o_insert_rob_has_rd,
    output dispatch_pkg::preg_idx_t      o_insert_rob_iprd [`RENAME_WIDTH],

    // frontend and decode exceptions, one cycle late
    output logic                         o_exceptwb_vld,
    output dispatch_pkg::rob_idx_t       o_exceptwb_rob_idx,
    output dispatch_pkg::except_t        o_exceptwb_cause,

    // immediate buffer access from issue and writeback
    input  dispatch_pkg::irob_idx_t      i_read_irob_idx [`IMMBUF_READPORT_NUM],
    output dispatch_pkg::imm_t           o_read_irob_data [`IMMBUF_READPORT_NUM],
    input  wire  [`IMMBUF_CLEARPORT_NUM-1:0] i_clear_irob_vld,
    input  dispatch_pkg::irob_idx_t      i_clear_irob_idx [`IMMBUF_CLEARPORT_NUM],

    // integer issue side
    output logic [`INTDQ_DISP_WID-1:0]   o_intq_deq_vld,
    input  wire  [`INTDQ_DISP_WID-1:0]   i_intq_deq_req,
    output dispatch_pkg::rob_idx_t       o_intq_deq_rob_idx [`INTDQ_DISP_WID],
    output dispatch_pkg::irob_idx_t      o_intq_deq_irob_idx [`INTDQ_DISP_WID],
    output logic [`INTDQ_DISP_WID-1:0]   o_intq_deq_use_imm,
    output dispatch_pkg::preg_idx_t      o_intq_deq_iprd [`INTDQ_DISP_WID],
    output dispatch_pkg::preg_idx_t      o_intq_deq_iprs1 [`INTDQ_DISP_WID],
    output dispatch_pkg::preg_idx_t      o_intq_deq_iprs2 [`INTDQ_DISP_WID],
    output dispatch_pkg::micop_t         o_intq_deq_micop [`INTDQ_DISP_WID]
);

    logic                     can_insert_intq;
    logic                     can_insert_immbuf;
    logic                     can_dispatch;
    logic                     disp_fire;
    logic [`RENAME_WIDTH-1:0] intq_req;
    logic [`RENAME_WIDTH-1:0] imm_req;
    dispatch_pkg::irob_idx_t  irob_alloc_idx [`RENAME_WIDTH];

    // memory queue is not modelled and never blocks
    assign can_dispatch = i_can_insert_rob && can_insert_intq && can_insert_immbuf;

    // whole group goes or nothing does
    assign disp_fire        = i_enq_vld[0] && can_dispatch;
    assign o_stall          = i_enq_vld[0] && !can_dispatch;
    assign o_insert_rob_vld = disp_fire;
    assign o_insert_rob_req = i_enq_vld;

    genvar i;
    generate
        for (i = 0; i < `RENAME_WIDTH; i++) begin : g_lane
            // moves were completed by rename, rob only
            assign intq_req[i] = i_enq_vld[i] && (i_enq_target[i] == dispatch_pkg::DISP_INT)
                                 && !i_enq_is_mv[i];
            // only integer queue entries carry an immediate slot
            assign imm_req[i]             = intq_req[i] && i_enq_use_imm[i];
            assign o_insert_rob_ismv[i]   = i_enq_is_mv[i];
            assign o_insert_rob_has_rd[i] = i_enq_rd_wen[i];
            assign o_insert_rob_iprd[i]   = i_enq_iprd[i];
        end
    endgenerate

    // oldest faulting lane wins
    logic                   exc_any;
    dispatch_pkg::rob_idx_t exc_rob_idx;
    dispatch_pkg::except_t  exc_cause;

    always_comb begin
        exc_any     = 1'b0;
        exc_rob_idx = i_alloc_rob_idx[0];
        exc_cause   = i_enq_except[0];
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            if (!exc_any && i_enq_vld[l] && i_enq_has_except[l]) begin
                exc_any     = 1'b1;
                exc_rob_idx = i_alloc_rob_idx[l];
                exc_cause   = i_enq_except[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_exceptwb_vld <= 1'b0;
        end else begin
            o_exceptwb_vld <= disp_fire && exc_any;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire && exc_any) begin
            o_exceptwb_rob_idx <= exc_rob_idx;
            o_exceptwb_cause   <= exc_cause;
        end
    end

    int_disp_queue #(
        .DEPTH   (`INTDQ_DEPTH),
        .IN_NUM  (`RENAME_WIDTH),
        .OUT_NUM (`INTDQ_DISP_WID)
    ) u_int_disp_queue (
        .clk            (clk),
        .rst            (rst),
        .i_flush        (i_squash),
        .o_can_enq      (can_insert_intq),
        .i_enq_vld      (disp_fire),
        .i_enq_req      (intq_req),
        .i_enq_rob_idx  (i_alloc_rob_idx),
        .i_enq_irob_idx (irob_alloc_idx),
        .i_enq_use_imm  (i_enq_use_imm),
        .i_enq_iprd     (i_enq_iprd),
        .i_enq_iprs1    (i_enq_iprs1),
        .i_enq_iprs2    (i_enq_iprs2),
        .i_enq_micop    (i_enq_micop),
        .o_deq_vld      (o_intq_deq_vld),
        .i_deq_req      (i_intq_deq_req),
        .o_deq_rob_idx  (o_intq_deq_rob_idx),
        .o_deq_irob_idx (o_intq_deq_irob_idx),
        .o_deq_use_imm  (o_intq_deq_use_imm),
        .o_deq_iprd     (o_intq_deq_iprd),
        .o_deq_iprs1    (o_intq_deq_iprs1),
        .o_deq_iprs2    (o_intq_deq_iprs2),
        .o_deq_micop    (o_intq_deq_micop)
    );

    // slot freed at writeback, not at issue
    imm_buffer #(
        .SIZE      (`IMMBUF_SIZE),
        .IN_NUM    (`RENAME_WIDTH),
        .READ_NUM  (`IMMBUF_READPORT_NUM),
        .CLEAR_NUM (`IMMBUF_CLEARPORT_NUM)
    ) u_imm_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_flush     (i_squash),
        .o_can_enq   (can_insert_immbuf),
        .i_enq_vld   (disp_fire),
        .i_enq_req   (imm_req),
        .i_enq_imm   (i_enq_imm),
        .o_alloc_idx (irob_alloc_idx),
        .i_read_idx  (i_read_irob_idx),
        .o_read_data (o_read_irob_data),
        .i_clear_vld (i_clear_irob_vld),
        .i_clear_idx (i_clear_irob_idx)
    );

endmodule

`default_nettype wire

// ==== sim/dispatch_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_config.svh"

module dispatch_sva (
    input wire                            clk,
    input wire                            rst,
    input wire                            i_squash,
    input wire [`RENAME_WIDTH-1:0]        i_enq_vld,
    input wire [`RENAME_WIDTH-1:0]        i_enq_has_except,
    input dispatch_pkg::except_t          i_enq_except [`RENAME_WIDTH],
    input dispatch_pkg::rob_idx_t         i_alloc_rob_idx [`RENAME_WIDTH],
    input wire                            i_can_insert_rob,
    input wire [`INTDQ_DISP_WID-1:0]      i_intq_deq_req,
    input wire [`INTDQ_DISP_WID-1:0]      o_intq_deq_vld,
    input wire                            o_stall,
    input wire                            o_insert_rob_vld,
    input wire                            o_exceptwb_vld,
    input dispatch_pkg::rob_idx_t         o_exceptwb_rob_idx,
    input dispatch_pkg::except_t          o_exceptwb_cause
);

    int unsigned fail_count = 0;

    a_rob_full: assert property (@(posedge clk) disable iff (rst)
        i_enq_vld[0] && !i_can_insert_rob |-> o_stall)
        else begin
            fail_count++;
            $error("full rob did not stall the group");
        end

    // a stalled group writes nothing into the integer queue
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        o_stall && !i_squash && i_intq_deq_req == '0 |=> $stable(o_intq_deq_vld))
        else begin
            fail_count++;
            $error("integer queue changed during a stall");
        end

    a_exc_lane0: assert property (@(posedge clk) disable iff (rst)
        o_insert_rob_vld && i_enq_vld[0] && i_enq_has_except[0] |=>
        o_exceptwb_vld && o_exceptwb_rob_idx == $past(i_alloc_rob_idx[0])
        && o_exceptwb_cause == $past(i_enq_except[0]))
        else begin
            fail_count++;
            $error("lane 0 exception not reported");
        end

    a_exc_lane1: assert property (@(posedge clk) disable iff (rst)
        o_insert_rob_vld && !i_enq_has_except[0] && i_enq_vld[1] && i_enq_has_except[1]
        |=> o_exceptwb_vld && o_exceptwb_rob_idx == $past(i_alloc_rob_idx[1])
        && o_exceptwb_cause == $past(i_enq_except[1]))
        else begin
            fail_count++;
            $error("lane 1 exception not reported");
        end

    a_exc_none: assert property (@(posedge clk) disable iff (rst)
        !(o_insert_rob_vld && |(i_enq_vld & i_enq_has_except)) |=> !o_exceptwb_vld)
        else begin
            fail_count++;
            $error("exception reported without a faulting lane");
        end

    a_squash: assert property (@(posedge clk) disable iff (rst)
        i_squash |=> o_intq_deq_vld == '0)
        else begin
            fail_count++;
            $error("integer queue not empty after squash");
        end

endmodule

bind dispatch dispatch_sva u_dispatch_sva (.*);

`default_nettype wire

// ==== sim/dispatch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_config.svh"

module dispatch_tb;

    localparam int RW = `RENAME_WIDTH;
    localparam int DW = `INTDQ_DISP_WID;
    localparam int RAND_CYCLES = 400;
    localparam int TOTAL_CYCLES = 10 + RAND_CYCLES + 30;

    logic clk = 1'b0;
    logic rst;
    logic i_squash;

    logic                          o_stall;
    logic [RW-1:0]                 i_enq_vld;
    dispatch_pkg::disp_target_t    i_enq_target [RW];
    logic [RW-1:0]                 i_enq_is_mv;
    logic [RW-1:0]                 i_enq_use_imm;
    dispatch_pkg::imm_t            i_enq_imm [RW];
    logic [RW-1:0]                 i_enq_rd_wen;
    dispatch_pkg::preg_idx_t       i_enq_iprd [RW];
    dispatch_pkg::preg_idx_t       i_enq_iprs1 [RW];
    dispatch_pkg::preg_idx_t       i_enq_iprs2 [RW];
    dispatch_pkg::micop_t          i_enq_micop [RW];
    logic [RW-1:0]                 i_enq_has_except;
    dispatch_pkg::except_t         i_enq_except [RW];

    logic                          i_can_insert_rob;
    dispatch_pkg::rob_idx_t        i_alloc_rob_idx [RW];
    logic                          o_insert_rob_vld;
    logic [RW-1:0]                 o_insert_rob_req;
    logic [RW-1:0]                 o_insert_rob_ismv;
    logic [RW-1:0]                 o_insert_rob_has_rd;
    dispatch_pkg::preg_idx_t       o_insert_rob_iprd [RW];

    logic                          o_exceptwb_vld;
    dispatch_pkg::rob_idx_t        o_exceptwb_rob_idx;
    dispatch_pkg::except_t         o_exceptwb_cause;

    dispatch_pkg::irob_idx_t       i_read_irob_idx [`IMMBUF_READPORT_NUM];
    dispatch_pkg::imm_t            o_read_irob_data [`IMMBUF_READPORT_NUM];
    logic [`IMMBUF_CLEARPORT_NUM-1:0] i_clear_irob_vld;
    dispatch_pkg::irob_idx_t       i_clear_irob_idx [`IMMBUF_CLEARPORT_NUM];

    logic [DW-1:0]                 o_intq_deq_vld;
    logic [DW-1:0]                 i_intq_deq_req;
    dispatch_pkg::rob_idx_t        o_intq_deq_rob_idx [DW];
    dispatch_pkg::irob_idx_t       o_intq_deq_irob_idx [DW];
    logic [DW-1:0]                 o_intq_deq_use_imm;
    dispatch_pkg::preg_idx_t       o_intq_deq_iprd [DW];
    dispatch_pkg::preg_idx_t       o_intq_deq_iprs1 [DW];
    dispatch_pkg::preg_idx_t       o_intq_deq_iprs2 [DW];
    dispatch_pkg::micop_t          o_intq_deq_micop [DW];

    // expected integer queue contents, oldest first
    dispatch_pkg::rob_idx_t        q_rob [$];
    dispatch_pkg::preg_idx_t       q_rd [$];
    dispatch_pkg::preg_idx_t       q_rs1 [$];
    dispatch_pkg::preg_idx_t       q_rs2 [$];
    dispatch_pkg::micop_t          q_micop [$];
    logic                          q_use [$];
    dispatch_pkg::irob_idx_t       q_slot [$];

    // expected immediate buffer state
    dispatch_pkg::imm_t            slot_imm [`IMMBUF_SIZE];
    logic [`IMMBUF_SIZE-1:0]       slot_busy;
    dispatch_pkg::irob_idx_t       clear_pend [$];

    dispatch_pkg::rob_idx_t        rob_ptr;
    logic [15:0]                   lfsr;
    logic                          deq_heavy;
    logic                          clear_on;
    logic                          fired;

    dispatch i_dut (.*);

    always #4 clk = ~clk;

    // taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic expect_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_idle();
        i_enq_vld        = '0;
        i_enq_is_mv      = '0;
        i_enq_use_imm    = '0;
        i_enq_rd_wen     = '0;
        i_enq_has_except = '0;
        for (int l = 0; l < RW; l++) begin
            i_enq_target[l]    = dispatch_pkg::DISP_INT;
            i_enq_imm[l]       = '0;
            i_enq_iprd[l]      = '0;
            i_enq_iprs1[l]     = '0;
            i_enq_iprs2[l]     = '0;
            i_enq_micop[l]     = '0;
            i_enq_except[l]    = '0;
            i_alloc_rob_idx[l] = rob_ptr + dispatch_pkg::rob_idx_t'(l);
        end
    endtask

    // valid lanes form a prefix
    task automatic new_group();
        for (int l = 0; l < RW; l++) begin
            if (l == 0) begin
                i_enq_vld[l] = rand_bits(2) != 0;
            end else begin
                i_enq_vld[l] = i_enq_vld[l-1] && rand_bits(1) != 0;
            end
            i_enq_target[l] = (rand_bits(2) == 0) ? dispatch_pkg::DISP_MEM
                                                  : dispatch_pkg::DISP_INT;
            i_enq_is_mv[l]      = rand_bits(3) == 0;
            i_enq_use_imm[l]    = rand_bits(3) < 5;
            i_enq_imm[l]        = 20'(rand_bits(20));
            i_enq_rd_wen[l]     = rand_bits(1) != 0;
            i_enq_iprd[l]       = 6'(rand_bits(6));
            i_enq_iprs1[l]      = 6'(rand_bits(6));
            i_enq_iprs2[l]      = 6'(rand_bits(6));
            i_enq_micop[l]      = 7'(rand_bits(7));
            i_enq_has_except[l] = rand_bits(4) == 0;
            i_enq_except[l]     = 4'(rand_bits(4));
            i_alloc_rob_idx[l]  = rob_ptr + dispatch_pkg::rob_idx_t'(l);
        end
    endtask

    // entered 1 ns after a rising edge, returns 1 ns after the next one
    task automatic step();
        int deq_n;
        int free_q;
        int free_b;
        logic exp_fire;
        dispatch_pkg::irob_idx_t slot;
        deq_n = 0;
        for (int k = 0; k < DW; k++) begin
            if (deq_n == k && o_intq_deq_vld[k] && (deq_heavy || rand_bits(2) == 0)) begin
                deq_n++;
            end
        end
        for (int k = 0; k < DW; k++) begin
            i_intq_deq_req[k]  = k < deq_n;
            i_read_irob_idx[k] = o_intq_deq_irob_idx[k];
        end
        i_clear_irob_vld = '0;
        for (int c = 0; c < `IMMBUF_CLEARPORT_NUM; c++) begin
            if (clear_on && clear_pend.size() > 0) begin
                i_clear_irob_idx[c] = clear_pend.pop_front();
                i_clear_irob_vld[c] = 1'b1;
            end
        end
        #6;
        free_q = `INTDQ_DEPTH - q_rob.size();
        free_b = 0;
        for (int s = 0; s < `IMMBUF_SIZE; s++) begin
            if (!slot_busy[s]) begin
                free_b++;
            end
        end
        exp_fire = i_enq_vld[0] && i_can_insert_rob && free_q >= RW && free_b >= RW;
        expect_hex("o_stall", i_enq_vld[0] && !exp_fire, o_stall);
        expect_hex("o_insert_rob_vld", exp_fire, o_insert_rob_vld);
        expect_hex("o_insert_rob_req", i_enq_vld, o_insert_rob_req);
        expect_hex("o_insert_rob_ismv", i_enq_is_mv, o_insert_rob_ismv);
        expect_hex("o_insert_rob_has_rd", i_enq_rd_wen, o_insert_rob_has_rd);
        for (int l = 0; l < RW; l++) begin
            expect_hex("o_insert_rob_iprd", i_enq_iprd[l], o_insert_rob_iprd[l]);
        end
        for (int k = 0; k < DW; k++) begin
            expect_hex("o_intq_deq_vld", q_rob.size() > k, o_intq_deq_vld[k]);
        end
        for (int k = 0; k < deq_n; k++) begin
            expect_hex("o_intq_deq_rob_idx", q_rob[0], o_intq_deq_rob_idx[k]);
            expect_hex("o_intq_deq_iprd", q_rd[0], o_intq_deq_iprd[k]);
            expect_hex("o_intq_deq_iprs1", q_rs1[0], o_intq_deq_iprs1[k]);
            expect_hex("o_intq_deq_iprs2", q_rs2[0], o_intq_deq_iprs2[k]);
            expect_hex("o_intq_deq_micop", q_micop[0], o_intq_deq_micop[k]);
            expect_hex("o_intq_deq_use_imm", q_use[0], o_intq_deq_use_imm[k]);
            if (q_use[0]) begin
                expect_hex("o_intq_deq_irob_idx", q_slot[0], o_intq_deq_irob_idx[k]);
                expect_hex("o_read_irob_data", slot_imm[q_slot[0]], o_read_irob_data[k]);
                clear_pend.push_back(q_slot[0]);
            end
            void'(q_rob.pop_front());
            void'(q_rd.pop_front());
            void'(q_rs1.pop_front());
            void'(q_rs2.pop_front());
            void'(q_micop.pop_front());
            void'(q_use.pop_front());
            void'(q_slot.pop_front());
        end
        if (i_squash) begin
            q_rob.delete();
            q_rd.delete();
            q_rs1.delete();
            q_rs2.delete();
            q_micop.delete();
            q_use.delete();
            q_slot.delete();
            clear_pend.delete();
            slot_busy = '0;
        end else begin
            if (exp_fire) begin
                for (int l = 0; l < RW; l++) begin
                    if (i_enq_vld[l] && i_enq_target[l] == dispatch_pkg::DISP_INT
                            && !i_enq_is_mv[l]) begin
                        slot = '0;
                        if (i_enq_use_imm[l]) begin
                            for (int s = `IMMBUF_SIZE - 1; s >= 0; s--) begin
                                if (!slot_busy[s]) begin
                                    slot = dispatch_pkg::irob_idx_t'(s);
                                end
                            end
                            slot_busy[slot] = 1'b1;
                            slot_imm[slot]  = i_enq_imm[l];
                        end
                        q_rob.push_back(i_alloc_rob_idx[l]);
                        q_rd.push_back(i_enq_iprd[l]);
                        q_rs1.push_back(i_enq_iprs1[l]);
                        q_rs2.push_back(i_enq_iprs2[l]);
                        q_micop.push_back(i_enq_micop[l]);
                        q_use.push_back(i_enq_use_imm[l]);
                        q_slot.push_back(slot);
                    end
                end
            end
            // cleared slots were busy, never the ones just allocated
            for (int c = 0; c < `IMMBUF_CLEARPORT_NUM; c++) begin
                if (i_clear_irob_vld[c]) begin
                    slot_busy[i_clear_irob_idx[c]] = 1'b0;
                end
            end
        end
        if (exp_fire) begin
            for (int l = 0; l < RW; l++) begin
                if (i_enq_vld[l]) begin
                    rob_ptr = rob_ptr + 1'b1;
                end
            end
        end
        fired = exp_fire || !i_enq_vld[0];
        @(posedge clk);
        #1;
        if (i_dut.u_dispatch_sva.fail_count != 0) begin
            $display("RESULT: FAIL");
            $fatal(1, "bound assertion failed");
        end
    endtask

    initial begin
        #(TOTAL_CYCLES * 8 + 400);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        lfsr             = 16'd78;
        rst              = 1'b1;
        i_squash         = 1'b0;
        i_can_insert_rob = 1'b0;
        i_intq_deq_req   = '0;
        i_clear_irob_vld = '0;
        for (int p = 0; p < `IMMBUF_READPORT_NUM; p++) begin
            i_read_irob_idx[p] = '0;
        end
        for (int c = 0; c < `IMMBUF_CLEARPORT_NUM; c++) begin
            i_clear_irob_idx[c] = '0;
        end
        rob_ptr   = '0;
        slot_busy = '0;
        deq_heavy = 1'b0;
        clear_on  = 1'b1;
        fired     = 1'b1;
        drive_idle();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        expect_hex("o_insert_rob_vld", 0, o_insert_rob_vld);
        expect_hex("o_exceptwb_vld", 0, o_exceptwb_vld);
        expect_hex("o_intq_deq_vld", 0, o_intq_deq_vld);
        expect_hex("o_stall", 0, o_stall);

        // alternate slow and fast drain so both queues fill up
        for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
            deq_heavy        = ((cyc / 32) % 2) == 1;
            clear_on         = ((cyc / 48) % 2) == 0 || rand_bits(2) == 0;
            i_squash         = rand_bits(6) == 0;
            i_can_insert_rob = rand_bits(3) != 0;
            if (fired) begin
                new_group();
            end
            step();
        end

        drive_idle();
        i_squash = 1'b1;
        step();
        i_squash = 1'b0;
        expect_hex("o_intq_deq_vld", 0, o_intq_deq_vld);
        i_can_insert_rob = 1'b1;
        new_group();
        i_enq_vld     = '1;
        i_enq_is_mv   = '0;
        i_enq_use_imm = '1;
        for (int l = 0; l < RW; l++) begin
            i_enq_target[l] = dispatch_pkg::DISP_INT;
        end
        step();
        deq_heavy = 1'b1;
        clear_on  = 1'b1;
        repeat (12) begin
            drive_idle();
            step();
        end

        if (i_dut.u_dispatch_sva.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/dispatch_pkg.sv
rtl/int_disp_queue.sv
rtl/imm_buffer.sv
rtl/dispatch.sv
sim/dispatch_sva.sv
sim/dispatch_tb.sv

// ==== Makefile ====
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module dispatch_tb \
		-f verilog.f --Mdir $(BUILD) -o dispatch_sim
	./$(BUILD)/dispatch_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "^RESULT: PASS" sim.log

clean:
	rm -rf $(BUILD) sim.log
